/* common/corebus_pkg.sv */
package corebus_pkg;
  typedef enum logic [0:0] {
    COREBUS_MEMORY_PROFILE   = 1'b0,
    COREBUS_REGISTER_PROFILE = 1'b1
  } corebus_profile_e;

  typedef enum logic [1:0] {
    COREBUS_READ         = 2'b00,
    COREBUS_WRITE        = 2'b01,
    COREBUS_POSTED_WRITE = 2'b10,
    COREBUS_ATOMIC       = 2'b11
  } corebus_command_kind_e;

  typedef enum logic [0:0] {
    COREBUS_READ_RESPONSE = 1'b0,
    COREBUS_WRITE_ACK     = 1'b1
  } corebus_response_kind_e;

  localparam int ID_WIDTH      = 4;
  localparam int ADDRESS_WIDTH = 32;
  localparam int LENGTH_WIDTH  = 8;
  localparam int DATA_WIDTH    = 32;

  // one enable per data byte
  localparam int BYTE_ENABLE_WIDTH = DATA_WIDTH / 8;

  // 2 + 4 + 32 + 8 = 46 bits
  typedef struct packed {
    corebus_command_kind_e    kind;
    logic [ID_WIDTH-1:0]      id;
    logic [ADDRESS_WIDTH-1:0] address;
    logic [LENGTH_WIDTH-1:0]  length;   // burst length
  } corebus_command_t;

  // 32 + 4 + 1 = 37 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0]        data;
    logic [BYTE_ENABLE_WIDTH-1:0] byte_enable;
    logic                         last;
  } corebus_write_data_t;

  // 1 + 4 + 32 + 1 = 38 bits
  typedef struct packed {
    corebus_response_kind_e kind;
    logic [ID_WIDTH-1:0]    id;
    logic [DATA_WIDTH-1:0]  data;     // read data, don't care on write ack
    logic                   last;
  } corebus_response_t;
endpackage

/* slicer/slicer_stage.sv */
module slicer_stage #(
  parameter type  payload_t      = logic [7:0],
  parameter bit   FULL_BANDWIDTH = 1
)(
  input  var logic      i_clk,
  input  var logic      i_arst_n,
  input  var logic      i_valid,
  output var logic      o_accept,
  input  var payload_t  i_payload,
  output var logic      o_valid,
  input  var logic      i_accept,
  output var payload_t  o_payload
);
  if (FULL_BANDWIDTH) begin : g_full
    // two-entry skid buffer where main always holds the oldest item
    logic [1:0] count;
    payload_t   main_payload;
    payload_t   skid_payload;
    logic       push;
    logic       pop;

    assign push      = i_valid && o_accept;
    assign pop       = o_valid && i_accept;
    assign o_accept  = !count[1];   // count == 2 means full
    assign o_valid   = count != 2'd0;
    assign o_payload = main_payload;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        count <= 2'd0;
      end else if (push && !pop) begin
        count <= count + 2'd1;
      end else if (pop && !push) begin
        count <= count - 2'd1;
      end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        main_payload <= '0;
        skid_payload <= '0;
      end else begin
        case (count)
          2'd0: begin
            if (push) begin
              main_payload <= i_payload;
            end
          end
          2'd1: begin
            if (push && pop) begin
              main_payload <= i_payload;
            end else if (push) begin
              skid_payload <= i_payload;   // main still waiting downstream
            end
          end
          default: begin
            if (pop) begin
              main_payload <= skid_payload;
            end
          end
        endcase
      end
    end
  end else begin : g_half
    // single entry that takes a new item only when empty
    logic     full;
    payload_t payload;

    assign o_accept  = !full;
    assign o_valid   = full;
    assign o_payload = payload;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        full <= 1'b0;
      end else if (i_valid && !full) begin
        full <= 1'b1;
      end else if (full && i_accept) begin
        full <= 1'b0;
      end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        payload <= '0;
      end else if (i_valid && !full) begin
        payload <= i_payload;
      end
    end
  end
endmodule

/* slicer/slicer.sv */
module slicer #(
  parameter type  payload_t      = logic [7:0],
  parameter int   STAGES         = 1,
  parameter bit   FULL_BANDWIDTH = 1
)(
  input  var logic      i_clk,
  input  var logic      i_arst_n,
  input  var logic      i_valid,
  output var logic      o_accept,
  input  var payload_t  i_payload,
  output var logic      o_valid,
  input  var logic      i_accept,
  output var payload_t  o_payload
);
  if (STAGES == 0) begin : g_bypass
    // combinational path, accept follows the far side
    assign o_valid   = i_valid;
    assign o_accept  = i_accept;
    assign o_payload = i_payload;
  end else begin : g_chain
    // index 0 is the upstream side, index STAGES the downstream side
    logic     valid   [STAGES+1];
    logic     accept  [STAGES+1];
    payload_t payload [STAGES+1];

    assign valid[0]       = i_valid;
    assign o_accept       = accept[0];
    assign payload[0]     = i_payload;
    assign o_valid        = valid[STAGES];
    assign accept[STAGES] = i_accept;
    assign o_payload      = payload[STAGES];

    for (genvar i = 0; i < STAGES; ++i) begin : g_stage
      slicer_stage #(
        .payload_t      (payload_t      ),
        .FULL_BANDWIDTH (FULL_BANDWIDTH )
      ) u_stage (
        .i_clk      (i_clk        ),
        .i_arst_n   (i_arst_n     ),
        .i_valid    (valid[i]     ),
        .o_accept   (accept[i]    ),
        .i_payload  (payload[i]   ),
        .o_valid    (valid[i+1]   ),
        .i_accept   (accept[i+1]  ),
        .o_payload  (payload[i+1] )
      );
    end
  end
endmodule

/* source/request_slicer.sv */
module request_slicer #(
  parameter corebus_pkg::corebus_profile_e  PROFILE        = corebus_pkg::COREBUS_MEMORY_PROFILE,
  parameter int                             STAGES         = 1,
  parameter bit                             FULL_BANDWIDTH = 1
)(
  input  var logic                              i_clk,
  input  var logic                              i_arst_n,
  input  var logic                              i_cmd_valid,
  output var logic                              o_cmd_accept,
  input  var corebus_pkg::corebus_command_t     i_cmd,
  output var logic                              o_cmd_valid,
  input  var logic                              i_cmd_accept,
  output var corebus_pkg::corebus_command_t     o_cmd,
  input  var logic                              i_wdata_valid,
  output var logic                              o_wdata_accept,
  input  var corebus_pkg::corebus_write_data_t  i_wdata,
  output var logic                              o_wdata_valid,
  input  var logic                              i_wdata_accept,
  output var corebus_pkg::corebus_write_data_t  o_wdata
);
  // register-access profile has no write data worth slicing
  localparam int WRITE_DATA_STAGES =
    (PROFILE == corebus_pkg::COREBUS_MEMORY_PROFILE) ? STAGES : 0;

  slicer #(
    .payload_t      (corebus_pkg::corebus_command_t ),
    .STAGES         (STAGES                         ),
    .FULL_BANDWIDTH (FULL_BANDWIDTH                 )
  ) u_command_slicer (
    .i_clk      (i_clk        ),
    .i_arst_n   (i_arst_n     ),
    .i_valid    (i_cmd_valid  ),
    .o_accept   (o_cmd_accept ),
    .i_payload  (i_cmd        ),
    .o_valid    (o_cmd_valid  ),
    .i_accept   (i_cmd_accept ),
    .o_payload  (o_cmd        )
  );

  slicer #(
    .payload_t      (corebus_pkg::corebus_write_data_t  ),
    .STAGES         (WRITE_DATA_STAGES                  ),
    .FULL_BANDWIDTH (FULL_BANDWIDTH                     )
  ) u_write_data_slicer (
    .i_clk      (i_clk          ),
    .i_arst_n   (i_arst_n       ),
    .i_valid    (i_wdata_valid  ),
    .o_accept   (o_wdata_accept ),
    .i_payload  (i_wdata        ),
    .o_valid    (o_wdata_valid  ),
    .i_accept   (i_wdata_accept ),
    .o_payload  (o_wdata        )
  );
endmodule

/* source/response_slicer.sv */
module response_slicer #(
  parameter int STAGES         = 1,
  parameter bit FULL_BANDWIDTH = 1
)(
  input  var logic                            i_clk,
  input  var logic                            i_arst_n,
  input  var logic                            i_resp_valid,
  output var logic                            o_resp_accept,
  input  var corebus_pkg::corebus_response_t  i_resp,
  output var logic                            o_resp_valid,
  input  var logic                            i_resp_accept,
  output var corebus_pkg::corebus_response_t  o_resp
);
  // responses are always sliced, whatever the profile
  localparam int RESPONSE_STAGES = STAGES;

  // id and last ride inside the packed response, so they move with the data beat
  slicer #(
    .payload_t      (corebus_pkg::corebus_response_t  ),
    .STAGES         (RESPONSE_STAGES                  ),
    .FULL_BANDWIDTH (FULL_BANDWIDTH                   )
  ) u_response_slicer (
    .i_clk      (i_clk          ),
    .i_arst_n   (i_arst_n       ),
    .i_valid    (i_resp_valid   ),   // slave side
    .o_accept   (o_resp_accept  ),
    .i_payload  (i_resp         ),
    .o_valid    (o_resp_valid   ),   // master side
    .i_accept   (i_resp_accept  ),
    .o_payload  (o_resp         )
  );
endmodule

/* source/corebus_slicer.sv */
module corebus_slicer #(
  parameter corebus_pkg::corebus_profile_e  PROFILE        = corebus_pkg::COREBUS_MEMORY_PROFILE,
  parameter int                             STAGES         = 1,
  parameter bit                             FULL_BANDWIDTH = 1
)(
  input  var logic                              i_clk,
  input  var logic                              i_arst_n,
  input  var logic                              i_m_cmd_valid,
  output var logic                              o_m_cmd_accept,
  input  var corebus_pkg::corebus_command_t     i_m_cmd,
  input  var logic                              i_m_wdata_valid,
  output var logic                              o_m_wdata_accept,
  input  var corebus_pkg::corebus_write_data_t  i_m_wdata,
  output var logic                              o_m_resp_valid,
  input  var logic                              i_m_resp_accept,
  output var corebus_pkg::corebus_response_t    o_m_resp,
  output var logic                              o_s_cmd_valid,
  input  var logic                              i_s_cmd_accept,
  output var corebus_pkg::corebus_command_t     o_s_cmd,
  output var logic                              o_s_wdata_valid,
  input  var logic                              i_s_wdata_accept,
  output var corebus_pkg::corebus_write_data_t  o_s_wdata,
  input  var logic                              i_s_resp_valid,
  output var logic                              o_s_resp_accept,
  input  var corebus_pkg::corebus_response_t    i_s_resp
);
  request_slicer #(
    .PROFILE        (PROFILE        ),
    .STAGES         (STAGES         ),
    .FULL_BANDWIDTH (FULL_BANDWIDTH )
  ) u_request_slicer (
    .i_clk          (i_clk            ),
    .i_arst_n       (i_arst_n         ),
    .i_cmd_valid    (i_m_cmd_valid    ),
    .o_cmd_accept   (o_m_cmd_accept   ),
    .i_cmd          (i_m_cmd          ),
    .o_cmd_valid    (o_s_cmd_valid    ),
    .i_cmd_accept   (i_s_cmd_accept   ),
    .o_cmd          (o_s_cmd          ),
    .i_wdata_valid  (i_m_wdata_valid  ),
    .o_wdata_accept (o_m_wdata_accept ),
    .i_wdata        (i_m_wdata        ),
    .o_wdata_valid  (o_s_wdata_valid  ),
    .i_wdata_accept (i_s_wdata_accept ),
    .o_wdata        (o_s_wdata        )
  );

  // response runs slave to master
  response_slicer #(
    .STAGES         (STAGES         ),
    .FULL_BANDWIDTH (FULL_BANDWIDTH )
  ) u_response_slicer (
    .i_clk          (i_clk            ),
    .i_arst_n       (i_arst_n         ),
    .i_resp_valid   (i_s_resp_valid   ),
    .o_resp_accept  (o_s_resp_accept  ),
    .i_resp         (i_s_resp         ),
    .o_resp_valid   (o_m_resp_valid   ),
    .i_resp_accept  (i_m_resp_accept  ),
    .o_resp         (o_m_resp         )
  );
endmodule

/* tests/corebus_slicer_sva.sv */
module corebus_slicer_sva #(
  parameter int STAGES         = 1,
  parameter bit FULL_BANDWIDTH = 1
)(
  input var logic                              i_clk,
  input var logic                              i_arst_n,
  input var logic                              i_m_cmd_valid,
  input var logic                              o_m_cmd_accept,
  input var logic                              i_m_wdata_valid,
  input var logic                              o_m_wdata_accept,
  input var logic                              o_m_resp_valid,
  input var logic                              i_m_resp_accept,
  input var corebus_pkg::corebus_response_t    o_m_resp,
  input var logic                              o_s_cmd_valid,
  input var logic                              i_s_cmd_accept,
  input var corebus_pkg::corebus_command_t     o_s_cmd,
  input var logic                              o_s_wdata_valid,
  input var logic                              i_s_wdata_accept,
  input var corebus_pkg::corebus_write_data_t  o_s_wdata,
  input var logic                              i_s_resp_valid,
  input var logic                              o_s_resp_accept
);
  int unsigned cmd_in_count;
  int unsigned cmd_out_count;
  int unsigned wdata_in_count;
  int unsigned wdata_out_count;
  int unsigned resp_in_count;
  int unsigned resp_out_count;
  int          stream_cycles;      // cycles into a full-rate run that began empty
  int unsigned failure_count = 0;
  logic        all_high;
  logic        drained;
  logic        in_phase;

  // item n of each channel, every field taken from n, last on every fourth
  function automatic corebus_pkg::corebus_command_t command_item(int unsigned n);
    return '{kind: corebus_pkg::corebus_command_kind_e'(n[1:0]), id: n[5:2],
             address: 32'h4000_0000 | (n << 4), length: n[7:0]};
  endfunction

  function automatic corebus_pkg::corebus_write_data_t write_data_item(int unsigned n);
    return '{data: {n[15:0], ~n[15:0]}, byte_enable: n[3:0], last: n[1:0] == 2'b11};
  endfunction

  function automatic corebus_pkg::corebus_response_t response_item(int unsigned n);
    return '{kind: corebus_pkg::corebus_response_kind_e'(n[0]), id: n[4:1],
             data: n ^ 32'h5a5a_c3c3, last: n[1:0] == 2'b11};
  endfunction

  assign all_high = i_m_cmd_valid && i_m_wdata_valid && i_s_resp_valid
                 && i_s_cmd_accept && i_s_wdata_accept && i_m_resp_accept;
  assign drained  = cmd_in_count == cmd_out_count && wdata_in_count == wdata_out_count
                 && resp_in_count == resp_out_count;
  assign in_phase = all_high && (stream_cycles != 0 || drained);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cmd_in_count    <= 0;
      cmd_out_count   <= 0;
      wdata_in_count  <= 0;
      wdata_out_count <= 0;
      resp_in_count   <= 0;
      resp_out_count  <= 0;
      stream_cycles   <= 0;
    end else begin
      cmd_in_count    <= cmd_in_count + 32'(i_m_cmd_valid && o_m_cmd_accept);
      cmd_out_count   <= cmd_out_count + 32'(o_s_cmd_valid && i_s_cmd_accept);
      wdata_in_count  <= wdata_in_count + 32'(i_m_wdata_valid && o_m_wdata_accept);
      wdata_out_count <= wdata_out_count + 32'(o_s_wdata_valid && i_s_wdata_accept);
      resp_in_count   <= resp_in_count + 32'(i_s_resp_valid && o_s_resp_accept);
      resp_out_count  <= resp_out_count + 32'(o_m_resp_valid && i_m_resp_accept);
      if (!in_phase) begin
        stream_cycles <= 0;
      end else if (stream_cycles < STAGES) begin
        stream_cycles <= stream_cycles + 1;   // saturates at the pipeline depth
      end
    end
  end

  reset_state: assert property (@(posedge i_clk) $rose(i_arst_n) |->
    !o_s_cmd_valid && !o_s_wdata_valid && !o_m_resp_valid
    && o_m_cmd_accept && o_m_wdata_accept && o_s_resp_accept)
  else begin
    $error("outputs were not idle in the first cycle after reset");
    failure_count++;
  end

  command_order: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_s_cmd_valid && i_s_cmd_accept |-> o_s_cmd == command_item(cmd_out_count))
  else begin
    $error("error o_s_cmd 0x%h expected 0x%h", $sampled(o_s_cmd),
      command_item($sampled(cmd_out_count)));
    failure_count++;
  end

  write_data_order: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_s_wdata_valid && i_s_wdata_accept |-> o_s_wdata == write_data_item(wdata_out_count))
  else begin
    $error("error o_s_wdata 0x%h expected 0x%h", $sampled(o_s_wdata),
      write_data_item($sampled(wdata_out_count)));
    failure_count++;
  end

  response_order: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_m_resp_valid && i_m_resp_accept |-> o_m_resp == response_item(resp_out_count))
  else begin
    $error("error o_m_resp 0x%h expected 0x%h", $sampled(o_m_resp),
      response_item($sampled(resp_out_count)));
    failure_count++;
  end

  // a stalled output keeps its valid and its payload
  stall_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (!$past(o_s_cmd_valid && !i_s_cmd_accept) || (o_s_cmd_valid && $stable(o_s_cmd)))
    && (!$past(o_s_wdata_valid && !i_s_wdata_accept)
        || (o_s_wdata_valid && $stable(o_s_wdata)))
    && (!$past(o_m_resp_valid && !i_m_resp_accept) || (o_m_resp_valid && $stable(o_m_resp))))
  else begin
    $error("a stalled output dropped its valid or changed its payload");
    failure_count++;
  end

  no_extra_items: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    cmd_out_count <= cmd_in_count && wdata_out_count <= wdata_in_count
    && resp_out_count <= resp_in_count)
  else begin
    $error("more items left a channel than entered it");
    failure_count++;
  end

  full_rate_accept: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    FULL_BANDWIDTH && in_phase |-> o_m_cmd_accept && o_m_wdata_accept && o_s_resp_accept)
  else begin
    $error("an upstream accept went low while every valid and accept was high");
    failure_count++;
  end

  full_rate_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    FULL_BANDWIDTH && in_phase && stream_cycles >= STAGES |->
    o_s_cmd_valid && o_s_wdata_valid && o_m_resp_valid)
  else begin
    $error("a downstream valid went low after the pipeline had filled at full rate");
    failure_count++;
  end
endmodule

bind corebus_slicer corebus_slicer_sva #(
  .STAGES         (STAGES         ),
  .FULL_BANDWIDTH (FULL_BANDWIDTH )
) u_sva (.*);

/* tests/tb_corebus_slicer.sv */
module tb_corebus_slicer #(
  parameter int STAGES           = 2,
  parameter bit FULL_BANDWIDTH   = 1,
  parameter bit REGISTER_PROFILE = 0
);
  localparam corebus_pkg::corebus_profile_e PROFILE = REGISTER_PROFILE ?
    corebus_pkg::COREBUS_REGISTER_PROFILE : corebus_pkg::COREBUS_MEMORY_PROFILE;
  localparam int          ITEMS          = 200;
  localparam int          PHASE_CYCLES   = 40;
  localparam int          TIMEOUT_CYCLES = 1500;   // room for 200 items at one every 7 cycles
  localparam int unsigned SEED           = 32'h62d9;

  logic                             i_clk = 1'b0;
  logic                             i_arst_n;
  logic                             i_m_cmd_valid;
  logic                             o_m_cmd_accept;
  corebus_pkg::corebus_command_t    i_m_cmd;
  logic                             i_m_wdata_valid;
  logic                             o_m_wdata_accept;
  corebus_pkg::corebus_write_data_t i_m_wdata;
  logic                             o_m_resp_valid;
  logic                             i_m_resp_accept;
  corebus_pkg::corebus_response_t   o_m_resp;
  logic                             o_s_cmd_valid;
  logic                             i_s_cmd_accept;
  corebus_pkg::corebus_command_t    o_s_cmd;
  logic                             o_s_wdata_valid;
  logic                             i_s_wdata_accept;
  corebus_pkg::corebus_write_data_t o_s_wdata;
  logic                             i_s_resp_valid;
  logic                             o_s_resp_accept;
  corebus_pkg::corebus_response_t   i_s_resp;
  int                               cmd_sent       = 0;
  int                               wdata_sent     = 0;
  int                               resp_sent      = 0;
  int                               cmd_received   = 0;
  int                               wdata_received = 0;
  int                               resp_received  = 0;
  int                               cycle_count    = 0;

  corebus_slicer #(
    .PROFILE        (PROFILE        ),
    .STAGES         (STAGES         ),
    .FULL_BANDWIDTH (FULL_BANDWIDTH )
  ) u_dut (.*);

  always #5 i_clk = ~i_clk;

  function automatic corebus_pkg::corebus_command_t command_item(int unsigned n);
    return '{kind: corebus_pkg::corebus_command_kind_e'(n[1:0]), id: n[5:2],
             address: 32'h4000_0000 | (n << 4), length: n[7:0]};
  endfunction

  function automatic corebus_pkg::corebus_write_data_t write_data_item(int unsigned n);
    return '{data: {n[15:0], ~n[15:0]}, byte_enable: n[3:0], last: n[1:0] == 2'b11};
  endfunction

  function automatic corebus_pkg::corebus_response_t response_item(int unsigned n);
    return '{kind: corebus_pkg::corebus_response_kind_e'(n[0]), id: n[4:1],
             data: n ^ 32'h5a5a_c3c3, last: n[1:0] == 2'b11};
  endfunction

  function automatic bit random_bit();
    return $urandom_range(1, 0) == 1;
  endfunction

  // a raised valid stays up until its item is taken
  function automatic logic next_valid(logic valid, bit taken, int sent, bit full_rate);
    if (sent >= ITEMS) return 1'b0;
    if (valid && !taken) return 1'b1;
    return full_rate || random_bit();
  endfunction

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("sim failed");
      $fatal(1, "timeout, not every item arrived within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  always @(negedge i_clk) begin
    if (u_dut.u_sva.failure_count != 0) begin
      $display("sim failed");
      $fatal(1, "an assertion on the DUT failed");
    end
  end

  initial begin
    int cycle;
    bit full_rate;
    bit cmd_taken;
    bit wdata_taken;
    bit resp_taken;
    void'($urandom(SEED));
    cycle            = 0;
    i_arst_n         = 1'b0;
    i_m_cmd_valid    = 1'b0;
    i_m_cmd          = command_item(0);
    i_m_wdata_valid  = 1'b0;
    i_m_wdata        = write_data_item(0);
    i_s_resp_valid   = 1'b0;
    i_s_resp         = response_item(0);
    i_s_cmd_accept   = 1'b1;
    i_s_wdata_accept = 1'b1;
    i_m_resp_accept  = 1'b1;
    repeat (5) @(posedge i_clk);
    #1 i_arst_n = 1'b1;
    // idle first cycle, then the full-rate phase, then random traffic
    while (cmd_received < ITEMS || wdata_received < ITEMS || resp_received < ITEMS) begin
      @(negedge i_clk);
      cmd_taken       = i_m_cmd_valid && o_m_cmd_accept;
      wdata_taken     = i_m_wdata_valid && o_m_wdata_accept;
      resp_taken      = i_s_resp_valid && o_s_resp_accept;
      cmd_sent       += int'(cmd_taken);
      wdata_sent     += int'(wdata_taken);
      resp_sent      += int'(resp_taken);
      cmd_received   += int'(o_s_cmd_valid && i_s_cmd_accept);
      wdata_received += int'(o_s_wdata_valid && i_s_wdata_accept);
      resp_received  += int'(o_m_resp_valid && i_m_resp_accept);
      @(posedge i_clk);
      #1;
      full_rate        = cycle < PHASE_CYCLES;
      i_m_cmd_valid    = next_valid(i_m_cmd_valid, cmd_taken, cmd_sent, full_rate);
      i_m_cmd          = command_item(cmd_sent);
      i_m_wdata_valid  = next_valid(i_m_wdata_valid, wdata_taken, wdata_sent, full_rate);
      i_m_wdata        = write_data_item(wdata_sent);
      i_s_resp_valid   = next_valid(i_s_resp_valid, resp_taken, resp_sent, full_rate);
      i_s_resp         = response_item(resp_sent);
      i_s_cmd_accept   = full_rate || random_bit();
      i_s_wdata_accept = full_rate || random_bit();
      i_m_resp_accept  = full_rate || random_bit();
      cycle++;
    end
    @(negedge i_clk);
    if (u_dut.u_sva.failure_count == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("sim failed");
      $fatal(1, "assertion failures were recorded during the run");
    end
  end
endmodule

/* project.f */
common/corebus_pkg.sv
slicer/slicer_stage.sv
slicer/slicer.sv
source/request_slicer.sv
source/response_slicer.sv
source/corebus_slicer.sv
tests/corebus_slicer_sva.sv
tests/tb_corebus_slicer.sv

/* Makefile */
VERILATOR        ?= verilator
TOP              ?= tb_corebus_slicer
BUILD_DIR        ?= obj_dir
STAGES           ?= 2
FULL_BANDWIDTH   ?= 1
REGISTER_PROFILE ?= 0
VFLAGS           ?= --binary --timing --assert -j 0
SIM_ARGS         ?= +verilator+error+limit+1000

PARAMS = -GSTAGES=$(STAGES) -GFULL_BANDWIDTH=$(FULL_BANDWIDTH) \
         -GREGISTER_PROFILE=$(REGISTER_PROFILE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(PARAMS) -f project.f --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

lint:
	$(VERILATOR) --lint-only -Wall --timing $(PARAMS) -f project.f --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
